// File: verilog.f
verilog/gcu_pkg.sv
verilog/gcu_vram_if.sv
verilog/gcu_cpu_port.sv
verilog/gcu_scroll_regs.sv
verilog/gcu_vram.sv
verilog/gcu_video_timing.sv
verilog/gcu_top.sv
verif/gcu_assert.sv
verif/gcu_tb.sv

// File: Makefile
# Verilator build and run for the graphics control unit testbench

VERILATOR ?= verilator
TOP       := gcu_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
PASS_MSG  := all tests passed

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/gcu_tb.sv
//**********************************************************************
// gcu directed testbench
// drives the host command port, renderer port and video timing inputs
// of the graphics control unit and checks every response
//**********************************************************************
module gcu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import gcu_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int ACK_LIMIT  = 8;
    localparam int RAM_BASE   = 'h0100;
    // reset, state, scroll, host ram, render, vint, sync
    localparam int TEST_CYCLES = 5 + 2 + 40 + 70 + 20 + 12 + 24;
    localparam int RUN_CYCLES  = 2 * TEST_CYCLES + 50;

    // command levels, select in the top bit
    localparam logic [5:0] OP_SELECT    = 6'b100000;
    localparam logic [5:0] OP_WRITE_REG = 6'b010000;
    localparam logic [5:0] OP_SET_PTR   = 6'b001000;
    localparam logic [5:0] OP_WRITE_RAM = 6'b000100;
    localparam logic [5:0] OP_READ_H    = 6'b000010;
    localparam logic [5:0] OP_READ_L    = 6'b000001;

    logic       CLK96 = 1'b0;
    logic       RESET96;
    logic [5:0] host_cmd;
    word_t      din;
    word_t      dout;
    logic       ack;
    logic       vint;
    pos_t       h;
    pos_t       v;
    pos_t       hs_start;
    pos_t       hs_end;
    pos_t       vs_start;
    pos_t       vs_end;
    logic       hsync;
    logic       vsync;
    logic       fblank;
    scroll_t    scroll [8];
    vram_addr_t render_addr;
    word_t      render_data;

    int          error_count = 0;
    int          test_errors = 0;
    int          check_count = 0;
    int          tests_run   = 0;
    logic [31:0] seed        = 32'd7;
    word_t       scroll_vals [8];
    word_t       ram_words [8];
    string       scroll_names [8] = '{"bg_scroll_x", "bg_scroll_y", "fg_scroll_x",
        "fg_scroll_y", "text_scroll_x", "text_scroll_y", "sprite_scroll_x",
        "sprite_scroll_y"};

    gcu_top UUT (
        .CLK96           (CLK96),
        .RESET96         (RESET96),
        .op_select_reg   (host_cmd[5]),
        .op_write_reg    (host_cmd[4]),
        .op_set_ram_ptr  (host_cmd[3]),
        .op_write_ram    (host_cmd[2]),
        .op_read_ram_h   (host_cmd[1]),
        .op_read_ram_l   (host_cmd[0]),
        .din             (din),
        .dout            (dout),
        .ack             (ack),
        .vint            (vint),
        .h               (h),
        .v               (v),
        .hs_start        (hs_start),
        .hs_end          (hs_end),
        .vs_start        (vs_start),
        .vs_end          (vs_end),
        .hsync           (hsync),
        .vsync           (vsync),
        .fblank          (fblank),
        .bg_scroll_x     (scroll[0]),
        .bg_scroll_y     (scroll[1]),
        .fg_scroll_x     (scroll[2]),
        .fg_scroll_y     (scroll[3]),
        .text_scroll_x   (scroll[4]),
        .text_scroll_y   (scroll[5]),
        .sprite_scroll_x (scroll[6]),
        .sprite_scroll_y (scroll[7]),
        .render_addr     (render_addr),
        .render_data     (render_data)
    );

    always #(CLK_PERIOD / 2) CLK96 = ~CLK96;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic count_error();
        error_count++;
        test_errors++;
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
            count_error();
        end
    endtask

    task automatic check_scroll(input string name, input scroll_t got, input scroll_t exp);
        check_count++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
            count_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
            count_error();
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s ok", name);
        end else begin
            $display("test %s saw %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // hold the level until ack, then drop it; din stays through the drop cycle
    task automatic run_command(input logic [5:0] op, input word_t data, input int low_exp);
        int low_seen;
        low_seen = 0;
        host_cmd = op;
        din = data;
        @(negedge CLK96);
        while (!ack && low_seen < ACK_LIMIT) begin
            low_seen++;
            @(negedge CLK96);
        end
        if (!ack) begin
            $display("ERROR at %0t ns: ack never returned high after command %b", $time, op);
            count_error();
        end else if (low_seen != low_exp) begin
            $display("CHECK FAILED at %0t ns: ack low cycles got %0d expected %0d",
                     $time, low_seen, low_exp);
            count_error();
        end
        host_cmd = '0;
        @(negedge CLK96);
    endtask

    task automatic select_reg(input word_t d);
        run_command(OP_SELECT, d, 0);
    endtask

    task automatic write_reg(input word_t d);
        run_command(OP_WRITE_REG, d, 0);
    endtask

    task automatic set_ram_ptr(input word_t d);
        run_command(OP_SET_PTR, d, 0);
    endtask

    task automatic write_ram(input word_t d);
        run_command(OP_WRITE_RAM, d, 1);
    endtask

    task automatic read_ram_h();
        run_command(OP_READ_H, '0, 2);
    endtask

    task automatic read_ram_l();
        run_command(OP_READ_L, '0, 2);
    endtask

    task automatic check_scroll_outputs();
        for (int i = 0; i < 8; i++) begin
            check_scroll(scroll_names[i], scroll[i], scroll_t'(scroll_vals[i][12:0]));
        end
    endtask

    task automatic test_reset_state();
        check_bit("ack", ack, 1'b1);
        check_bit("vint", vint, 1'b1);
        check_word("dout", dout, 16'h0000);
        for (int i = 0; i < 8; i++) begin
            scroll_vals[i] = '0;
        end
        check_scroll_outputs();
        finish_test("reset_state");
    endtask

    task automatic test_scroll_regs();
        // top bits set so the 13-bit truncation shows
        for (int i = 0; i < 8; i++) begin
            scroll_vals[i] = 16'hE005 + word_t'(i) * 16'h0111;
            select_reg(word_t'(i));
            write_reg(scroll_vals[i]);
        end
        check_scroll_outputs();
        select_reg(16'h0083);
        write_reg(16'h0ABC);
        scroll_vals[3] = 16'h0ABC;
        check_scroll_outputs();
        // unmapped register, nothing moves
        select_reg(16'h000A);
        write_reg(16'h1FFF);
        check_scroll_outputs();
        finish_test("scroll_regs");
    endtask

    task automatic test_ram_host();
        set_ram_ptr(word_t'(RAM_BASE));
        for (int i = 0; i < 8; i++) begin
            seed = lcg(seed);
            ram_words[i] = seed[31:16];
            write_ram(ram_words[i]);
        end
        for (int i = 0; i < 8; i += 2) begin
            set_ram_ptr(word_t'(RAM_BASE + i));
            read_ram_h();
            check_word("dout", dout, ram_words[i]);
            read_ram_l();
            check_word("dout", dout, ram_words[i + 1]);
        end
        finish_test("ram_host");
    endtask

    task automatic test_ram_render();
        for (int i = 0; i < 8; i++) begin
            render_addr = vram_addr_t'(RAM_BASE + i);
            @(negedge CLK96);
            check_word("render_data", render_data, ram_words[i]);
        end
        // second write lands past the top of the RAM
        set_ram_ptr(16'h1FFF);
        write_ram(16'hC0DE);
        write_ram(16'h0BAD);
        render_addr = 13'h1FFF;
        @(negedge CLK96);
        check_word("render_data", render_data, 16'hC0DE);
        render_addr = 13'h0000;
        @(negedge CLK96);
        check_word("render_data", render_data, 16'h0BAD);
        finish_test("ram_render");
    endtask

    task automatic test_vint();
        check_bit("vint", vint, 1'b1);
        v = 9'h0E6;
        @(negedge CLK96);
        check_bit("vint", vint, 1'b0);
        v = 9'h0E7;
        repeat (3) @(negedge CLK96);
        check_bit("vint", vint, 1'b0);
        select_reg(16'h0005);
        check_bit("vint", vint, 1'b0);
        select_reg(16'h000F);
        check_bit("vint", vint, 1'b1);
        v = '0;
        finish_test("vint");
    endtask

    // drive one h and v pair and compare the syncs and blank a cycle later
    task automatic apply_sync_point(input pos_t hv, input pos_t vv);
        logic exp_h;
        logic exp_v;
        h = hv;
        v = vv;
        // hsync high at or beyond its limits and vsync only beyond them
        exp_h = (hv <= hs_start) || (hv >= hs_end);
        exp_v = (vv < vs_start) || (vv > vs_end);
        @(negedge CLK96);
        check_bit("hsync", hsync, exp_h);
        check_bit("vsync", vsync, exp_v);
        check_bit("fblank", fblank, (!exp_h || !exp_v) ? 1'b0 : 1'b1);
    endtask

    task automatic test_sync_blank();
        hs_start = 9'd32;
        hs_end = 9'd96;
        vs_start = 9'd240;
        vs_end = 9'd250;
        for (int i = 0; i < 16; i++) begin
            seed = lcg(seed);
            apply_sync_point({2'b00, seed[22:16]}, 9'd230 + {4'b0000, seed[12:8]});
        end
        // both ends of each window
        apply_sync_point(hs_start, vs_start);
        apply_sync_point(hs_end, vs_end);
        apply_sync_point(hs_start + 9'd1, vs_start - 9'd1);
        apply_sync_point(hs_end - 9'd1, vs_end + 9'd1);
        finish_test("sync_blank");
    endtask

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("watchdog expired, run did not finish within %0d cycles", RUN_CYCLES);
        $display("tests failed");
        $finish;
    end

    initial begin
        RESET96 = 1'b1;
        host_cmd = '0;
        din = '0;
        h = '0;
        v = '0;
        hs_start = '0;
        hs_end = '0;
        vs_start = '0;
        vs_end = '0;
        render_addr = '0;
        repeat (4) @(posedge CLK96);
        @(negedge CLK96);
        RESET96 = 1'b0;
        test_reset_state();
        test_scroll_regs();
        test_ram_host();
        test_ram_render();
        test_vint();
        test_sync_blank();
        error_count += UUT.u_assert.fail_count;
        $display("%0d tests, %0d checks, %0d errors", tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: verif/gcu_assert.sv
//**********************************************************************
// gcu protocol assertions
// bound to the top level, checks ack length, RAM write strobe width
// and blank against the syncs
//**********************************************************************
module gcu_assert (
    input logic CLK96,
    input logic RESET96,
    input logic ack,
    input logic we,
    input logic hsync,
    input logic vsync,
    input logic fblank
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    // reads hold ack low two cycles, never longer
    ack_low_max: assert property (@(posedge CLK96) disable iff (RESET96)
        (!ack && !$past(ack)) |=> ack)
        else begin
            fail_count++;
            $error("ack low for more than two cycles");
        end

    write_strobe_single: assert property (@(posedge CLK96) disable iff (RESET96)
        we |=> !we)
        else begin
            fail_count++;
            $error("RAM write strobe longer than one cycle");
        end

    blank_follows_sync: assert property (@(posedge CLK96) disable iff (RESET96)
        (!hsync || !vsync) |-> !fblank)
        else begin
            fail_count++;
            $error("fblank high while a sync is low");
        end

endmodule

bind gcu_top gcu_assert u_assert (
    .CLK96   (CLK96),
    .RESET96 (RESET96),
    .ack     (ack),
    .we      (vram_bus.we),
    .hsync   (hsync),
    .vsync   (vsync),
    .fblank  (fblank)
);

// File: verilog/gcu_top.sv
//**********************************************************************
// gcu top level
// cpu-facing core of the tile and sprite graphics control unit,
// host command port, video RAM, scroll registers and video timing
//**********************************************************************
module gcu_top (
    input  logic                CLK96,
    input  logic                RESET96,
    input  logic                op_select_reg,
    input  logic                op_write_reg,
    input  logic                op_set_ram_ptr,
    input  logic                op_write_ram,
    input  logic                op_read_ram_h,
    input  logic                op_read_ram_l,
    input  gcu_pkg::word_t      din,
    output gcu_pkg::word_t      dout,
    output logic                ack,
    output logic                vint,
    input  gcu_pkg::pos_t       h,
    input  gcu_pkg::pos_t       v,
    input  gcu_pkg::pos_t       hs_start,
    input  gcu_pkg::pos_t       hs_end,
    input  gcu_pkg::pos_t       vs_start,
    input  gcu_pkg::pos_t       vs_end,
    output logic                hsync,
    output logic                vsync,
    output logic                fblank,
    output gcu_pkg::scroll_t    bg_scroll_x,
    output gcu_pkg::scroll_t    bg_scroll_y,
    output gcu_pkg::scroll_t    fg_scroll_x,
    output gcu_pkg::scroll_t    fg_scroll_y,
    output gcu_pkg::scroll_t    text_scroll_x,
    output gcu_pkg::scroll_t    text_scroll_y,
    output gcu_pkg::scroll_t    sprite_scroll_x,
    output gcu_pkg::scroll_t    sprite_scroll_y,
    input  gcu_pkg::vram_addr_t render_addr,
    output gcu_pkg::word_t      render_data
);
    import gcu_pkg::*;

    cmd_t     cmd;
    reg_num_t reg_num;
    logic     reg_write;
    logic     vint_ack;

    gcu_vram_if vram_bus ();

    // command levels packed select first
    assign cmd = {op_select_reg, op_write_reg, op_set_ram_ptr,
                  op_write_ram, op_read_ram_h, op_read_ram_l};

    gcu_cpu_port u_cpu_port (
        .CLK96     (CLK96),
        .RESET96   (RESET96),
        .cmd       (cmd),
        .din       (din),
        .vram      (vram_bus.cpu),
        .dout      (dout),
        .ack       (ack),
        .reg_num   (reg_num),
        .reg_write (reg_write),
        .vint_ack  (vint_ack)
    );

    gcu_scroll_regs u_scroll_regs (
        .CLK96           (CLK96),
        .RESET96         (RESET96),
        .reg_num         (reg_num),
        .reg_write       (reg_write),
        .din             (din),
        .bg_scroll_x     (bg_scroll_x),
        .bg_scroll_y     (bg_scroll_y),
        .fg_scroll_x     (fg_scroll_x),
        .fg_scroll_y     (fg_scroll_y),
        .text_scroll_x   (text_scroll_x),
        .text_scroll_y   (text_scroll_y),
        .sprite_scroll_x (sprite_scroll_x),
        .sprite_scroll_y (sprite_scroll_y)
    );

    gcu_vram u_vram (
        .CLK96       (CLK96),
        .host        (vram_bus.ram),
        .render_addr (render_addr),
        .render_data (render_data)
    );

    gcu_video_timing u_video_timing (
        .CLK96    (CLK96),
        .RESET96  (RESET96),
        .h        (h),
        .v        (v),
        .hs_start (hs_start),
        .hs_end   (hs_end),
        .vs_start (vs_start),
        .vs_end   (vs_end),
        .vint_ack (vint_ack),
        .hsync    (hsync),
        .vsync    (vsync),
        .fblank   (fblank),
        .vint     (vint)
    );

endmodule

// File: verilog/gcu_video_timing.sv
//**********************************************************************
// gcu video timing
// sync and blank from the H and V counters against programmable limits,
// plus the vertical interrupt latch
//**********************************************************************
module gcu_video_timing (
    input  logic          CLK96,
    input  logic          RESET96,
    input  gcu_pkg::pos_t h,
    input  gcu_pkg::pos_t v,
    input  gcu_pkg::pos_t hs_start,
    input  gcu_pkg::pos_t hs_end,
    input  gcu_pkg::pos_t vs_start,
    input  gcu_pkg::pos_t vs_end,
    input  logic          vint_ack,
    output logic          hsync,
    output logic          vsync,
    output logic          fblank,
    output logic          vint
);
    import gcu_pkg::*;

    // active low syncs, hsync window is open at both ends
    always_comb begin
        hsync  = !((h > hs_start) && (h < hs_end));
        vsync  = !((v >= vs_start) && (v <= vs_end));
        fblank = hsync && vsync;
    end

    // interrupt is active low, the acknowledge wins over the line match
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            vint <= 1'b1;
        end else if (vint_ack) begin
            vint <= 1'b1;
        end else if (v == VINT_LINE) begin
            vint <= 1'b0;
        end
    end

endmodule

// File: verilog/gcu_vram.sv
//**********************************************************************
// gcu video RAM
// 8K x 16 dual-port array, host read/write port and renderer read port
//**********************************************************************
module gcu_vram (
    input  logic                CLK96,
    gcu_vram_if.ram             host,
    input  gcu_pkg::vram_addr_t render_addr,
    output gcu_pkg::word_t      render_data
);
    import gcu_pkg::*;

    word_t mem [VRAM_WORDS];

    // port A, write and registered read at one address
    always_ff @(posedge CLK96) begin
        if (host.we) begin
            mem[host.addr] <= host.wdata;
        end
        host.rdata <= mem[host.addr];
    end

    // port B, read only for the layer and sprite renderers
    always_ff @(posedge CLK96) begin
        render_data <= mem[render_addr];
    end

endmodule

// File: verilog/gcu_scroll_regs.sv
//**********************************************************************
// gcu scroll registers
// x and y scroll for background, foreground, text and sprite layers
//**********************************************************************
module gcu_scroll_regs (
    input  logic              CLK96,
    input  logic              RESET96,
    input  gcu_pkg::reg_num_t reg_num,
    input  logic              reg_write,
    input  gcu_pkg::word_t    din,
    output gcu_pkg::scroll_t  bg_scroll_x,
    output gcu_pkg::scroll_t  bg_scroll_y,
    output gcu_pkg::scroll_t  fg_scroll_x,
    output gcu_pkg::scroll_t  fg_scroll_y,
    output gcu_pkg::scroll_t  text_scroll_x,
    output gcu_pkg::scroll_t  text_scroll_y,
    output gcu_pkg::scroll_t  sprite_scroll_x,
    output gcu_pkg::scroll_t  sprite_scroll_y
);
    import gcu_pkg::*;

    word_t    bg_x;
    word_t    bg_y;
    word_t    fg_x;
    word_t    fg_y;
    word_t    text_x;
    word_t    text_y;
    word_t    sprite_x;
    word_t    sprite_y;
    reg_num_t base_num;

    // 0x80 to 0x87 land on the same registers as 0 to 7
    assign base_num = reg_num & ~REG_ALIAS_BIT;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            bg_x     <= '0;
            bg_y     <= '0;
            fg_x     <= '0;
            fg_y     <= '0;
            text_x   <= '0;
            text_y   <= '0;
            sprite_x <= '0;
            sprite_y <= '0;
        end else if (reg_write) begin
            case (base_num)
                REG_BG_SCROLL_X:     bg_x     <= din;
                REG_BG_SCROLL_Y:     bg_y     <= din;
                REG_FG_SCROLL_X:     fg_x     <= din;
                REG_FG_SCROLL_Y:     fg_y     <= din;
                REG_TEXT_SCROLL_X:   text_x   <= din;
                REG_TEXT_SCROLL_Y:   text_y   <= din;
                REG_SPRITE_SCROLL_X: sprite_x <= din;
                REG_SPRITE_SCROLL_Y: sprite_y <= din;
                default: ;
            endcase
        end
    end

    // renderers see only the low bits of each word
    assign bg_scroll_x     = bg_x[SCROLL_W-1:0];
    assign bg_scroll_y     = bg_y[SCROLL_W-1:0];
    assign fg_scroll_x     = fg_x[SCROLL_W-1:0];
    assign fg_scroll_y     = fg_y[SCROLL_W-1:0];
    assign text_scroll_x   = text_x[SCROLL_W-1:0];
    assign text_scroll_y   = text_y[SCROLL_W-1:0];
    assign sprite_scroll_x = sprite_x[SCROLL_W-1:0];
    assign sprite_scroll_y = sprite_y[SCROLL_W-1:0];

endmodule

// File: verilog/gcu_cpu_port.sv
//**********************************************************************
// gcu cpu port
// decodes the level-held host commands, keeps the selected register
// and the video RAM pointer, and sequences RAM writes and reads
//**********************************************************************
module gcu_cpu_port (
    input  logic              CLK96,
    input  logic              RESET96,
    input  gcu_pkg::cmd_t     cmd,
    input  gcu_pkg::word_t    din,
    gcu_vram_if.cpu           vram,
    output gcu_pkg::word_t    dout,
    output logic              ack,
    output gcu_pkg::reg_num_t reg_num,
    output logic              reg_write,
    output logic              vint_ack
);
    import gcu_pkg::*;

    cpu_state_t state;
    cmd_t       last_cmd;
    vram_addr_t ram_ptr;
    reg_num_t   sel_num;
    logic       ready;
    logic       new_cmd;
    logic       sel_is_ack;
    logic       read_low;

    // commands are only taken between sequences
    assign ready   = (state == ST_IDLE) || (state == ST_HOLD);
    assign new_cmd = ready && (cmd != last_cmd);

    assign sel_num    = din[REG_W-1:0] & SCROLL_REG_MASK;
    assign sel_is_ack = (sel_num == VINT_ACK_REG0) ||
                        (sel_num == VINT_ACK_REG1) ||
                        (sel_num == VINT_ACK_REG2);

    // read low looks one word past the pointer
    assign read_low = cmd[CMD_READ_L] && !cmd[CMD_WRITE_RAM] && !cmd[CMD_READ_H];

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            state     <= ST_IDLE;
            last_cmd  <= '0;
            ack       <= 1'b1;
            reg_num   <= '0;
            ram_ptr   <= '0;
            dout      <= '0;
            reg_write <= 1'b0;
            vint_ack  <= 1'b0;
            vram.we   <= 1'b0;
        end else begin
            reg_write <= 1'b0;
            vint_ack  <= 1'b0;

            case (state)
                ST_IDLE, ST_HOLD: begin
                    if (new_cmd) begin
                        last_cmd <= cmd;
                        state    <= (cmd == '0) ? ST_IDLE : ST_HOLD;

                        // same priority as the host bus decoder
                        if (cmd[CMD_SELECT]) begin
                            reg_num  <= sel_num;
                            vint_ack <= sel_is_ack;
                        end else if (cmd[CMD_WRITE_REG]) begin
                            reg_write <= 1'b1;
                        end else if (cmd[CMD_SET_PTR]) begin
                            ram_ptr <= din[VRAM_AW-1:0];
                        end else if (cmd[CMD_WRITE_RAM]) begin
                            vram.we <= 1'b1;
                            ack     <= 1'b0;
                            state   <= ST_WRITE_DONE;
                        end else if (cmd[CMD_READ_H] || cmd[CMD_READ_L]) begin
                            ack   <= 1'b0;
                            state <= ST_READ_WAIT;
                        end
                    end
                end

                // RAM takes the word on this edge, pointer moves on
                ST_WRITE_DONE: begin
                    vram.we <= 1'b0;
                    ram_ptr <= ram_ptr + 1'b1;
                    ack     <= 1'b1;
                    state   <= ST_HOLD;
                end

                // RAM registers the word at the new address
                ST_READ_WAIT: begin
                    state <= ST_READ_CAPTURE;
                end

                ST_READ_CAPTURE: begin
                    dout  <= vram.rdata;
                    ack   <= 1'b1;
                    state <= ST_HOLD;
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // RAM address and data follow the pointer when a RAM command starts
    always_ff @(posedge CLK96) begin
        if (new_cmd && (cmd[CMD_SELECT:CMD_SET_PTR] == '0)) begin
            vram.addr  <= ram_ptr + vram_addr_t'(read_low);
            vram.wdata <= din;
        end
    end

endmodule

// File: verilog/gcu_vram_if.sv
//**********************************************************************
// gcu video RAM host port
// address, write data and strobe from the cpu port, read data back
// from the RAM one clock after the address
//**********************************************************************
interface gcu_vram_if;
    import gcu_pkg::*;

    vram_addr_t addr;
    word_t      wdata;
    logic       we;
    word_t      rdata;

    modport cpu (
        output addr,
        output wdata,
        output we,
        input  rdata
    );

    modport ram (
        input  addr,
        input  wdata,
        input  we,
        output rdata
    );

endinterface

// File: verilog/gcu_pkg.sv
//**********************************************************************
// gcu shared definitions
// widths, register numbers, host command vector and cpu port states
// for the tile and sprite graphics control unit
//**********************************************************************
package gcu_pkg;

    // bus and field widths
    localparam int WORD_W   = 16;
    localparam int VRAM_AW  = 13;
    localparam int REG_W    = 8;
    localparam int SCROLL_W = 13;
    localparam int POS_W    = 9;
    localparam int CMD_W    = 6;

    typedef logic [WORD_W-1:0]          word_t;
    typedef logic [VRAM_AW-1:0]         vram_addr_t;
    typedef logic [REG_W-1:0]           reg_num_t;
    typedef logic signed [SCROLL_W-1:0] scroll_t;
    typedef logic [POS_W-1:0]           pos_t;

    // host command levels, select in the top bit
    typedef logic [CMD_W-1:0] cmd_t;

    localparam int CMD_SELECT    = 5;
    localparam int CMD_WRITE_REG = 4;
    localparam int CMD_SET_PTR   = 3;
    localparam int CMD_WRITE_RAM = 2;
    localparam int CMD_READ_H    = 1;
    localparam int CMD_READ_L    = 0;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WRITE_DONE,
        ST_READ_WAIT,
        ST_READ_CAPTURE,
        ST_HOLD
    } cpu_state_t;

    localparam int VRAM_WORDS = 8192;

    // select stores din masked to these bits
    localparam reg_num_t SCROLL_REG_MASK = 8'h8F;
    // bit 7 aliases the plain scroll registers
    localparam reg_num_t REG_ALIAS_BIT   = 8'h80;

    localparam reg_num_t REG_BG_SCROLL_X     = 8'h00;
    localparam reg_num_t REG_BG_SCROLL_Y     = 8'h01;
    localparam reg_num_t REG_FG_SCROLL_X     = 8'h02;
    localparam reg_num_t REG_FG_SCROLL_Y     = 8'h03;
    localparam reg_num_t REG_TEXT_SCROLL_X   = 8'h04;
    localparam reg_num_t REG_TEXT_SCROLL_Y   = 8'h05;
    localparam reg_num_t REG_SPRITE_SCROLL_X = 8'h06;
    localparam reg_num_t REG_SPRITE_SCROLL_Y = 8'h07;

    // selecting any of these clears the vertical interrupt
    localparam reg_num_t VINT_ACK_REG0 = 8'h0E;
    localparam reg_num_t VINT_ACK_REG1 = 8'h0F;
    localparam reg_num_t VINT_ACK_REG2 = 8'h8F;

    localparam pos_t VINT_LINE = 9'h0E6;

endpackage
